//--- include/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// memory side: four banks of 32-bit words
`define LSU_BANKS 4
`define LSU_WORD_W 32

// word address into each bank
`define LSU_ADDR_W 14

// one beat is one word from every bank
`define LSU_BEAT_W 128

// largest register group, lmul of 4
`define LSU_GROUP_W 512

// beats in the largest group
`define LSU_MAX_BEATS 4

`endif

//--- verilog/lsu_pkg.sv
`include "lsu_settings.svh"

package lsu_pkg;

    // bank word and bank address
    typedef logic [`LSU_WORD_W-1:0] word_t;
    typedef logic [`LSU_ADDR_W-1:0] mem_addr_t;

    // one beat and one full register group
    typedef logic [`LSU_BEAT_W-1:0] beat_t;
    typedef logic [`LSU_GROUP_W-1:0] group_t;

    // beat slot in a group, and a count that also reaches max beats
    typedef logic [$clog2(`LSU_MAX_BEATS)-1:0] beat_idx_t;
    typedef logic [$clog2(`LSU_MAX_BEATS+1)-1:0] beat_cnt_t;

    // element stride, in elements
    typedef logic [5:0] stride_t;

    // vtype fields as raw codes
    typedef logic [2:0] sew_t;
    typedef logic [2:0] lmul_t;

    // codes 10 to 12 (strided stores) are left out and act as idle
    typedef enum logic [3:0] {
        VLSU_NONE   = 4'd0,
        VLSU_VLE8   = 4'd1,
        VLSU_VLE16  = 4'd2,
        VLSU_VLE32  = 4'd3,
        VLSU_VLSE8  = 4'd4,
        VLSU_VLSE16 = 4'd5,
        VLSU_VLSE32 = 4'd6,
        VLSU_VSE8   = 4'd7,
        VLSU_VSE16  = 4'd8,
        VLSU_VSE32  = 4'd9
    } lsu_op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_COMPACT,
        ST_STORE,
        ST_DONE
    } lsu_state_t;

endpackage

//--- verilog/load_ctrl_if.sv
interface load_ctrl_if import lsu_pkg::*; ();

    // zero the group register, first load cycle only
    logic clear;
    // bank read data is valid and goes into slot beat_idx
    logic capture;
    beat_idx_t beat_idx;
    // load the result register this cycle
    logic finish;
    // result takes the compacted group
    logic strided;

    modport seq (
        output clear,
        output capture,
        output beat_idx,
        output finish,
        output strided
    );

    modport asm (
        input clear,
        input capture,
        input beat_idx,
        input finish,
        input strided
    );

endinterface

//--- verilog/element_gather.sv
`include "lsu_settings.svh"

module element_gather import lsu_pkg::*; (
    input  group_t  group,
    input  sew_t    vsew,
    input  stride_t stride,
    output group_t  gathered
);

    // w = 0, 1, 2 for 8, 16 and 32-bit elements
    for (genvar w = 0; w < 3; w++) begin : g_sew
        localparam int EW = 8 << w;
        localparam int NE = `LSU_GROUP_W / EW;

        group_t compact;

        // element i takes source element i*stride, zero past the group
        always_comb begin
            int src;
            compact = '0;
            for (int i = 0; i < NE; i++) begin
                src = i * int'(stride);
                if (src < NE) begin
                    compact[i*EW +: EW] = group[src*EW +: EW];
                end
            end
        end
    end

    // stride 0 or 1 leaves the group as loaded
    always_comb begin
        if (stride <= stride_t'(1)) begin
            gathered = group;
        end else begin
            case (vsew)
                3'd0: gathered = g_sew[0].compact;
                3'd1: gathered = g_sew[1].compact;
                // 32-bit and the reserved codes
                default: gathered = g_sew[2].compact;
            endcase
        end
    end

endmodule

//--- verilog/load_assembler.sv
`include "lsu_settings.svh"

module load_assembler import lsu_pkg::*; (
    input  logic     clk,
    input  logic     nrst,
    load_ctrl_if.asm ctrl,
    input  word_t    l_data_in0,
    input  word_t    l_data_in1,
    input  word_t    l_data_in2,
    input  word_t    l_data_in3,
    input  sew_t     vsew,
    input  stride_t  stride,
    output group_t   l_data_out
);

    beat_t  rd_beat;
    group_t group_q;
    group_t group_next;
    group_t gathered;

    // bank 0 in the low word
    assign rd_beat = {l_data_in3, l_data_in2, l_data_in1, l_data_in0};

    // group with this cycle's beat already in place
    // so finish can land in the same cycle as the last capture
    always_comb begin
        group_next = group_q;
        if (ctrl.capture) begin
            group_next[ctrl.beat_idx*`LSU_BEAT_W +: `LSU_BEAT_W] = rd_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.clear) begin
            group_q <= '0;
        end else begin
            group_q <= group_next;
        end
    end

    element_gather u_gather (
        .group    (group_next),
        .vsew     (vsew),
        .stride   (stride),
        .gathered (gathered)
    );

    // result holds until the next finish
    always_ff @(posedge clk) begin
        if (!nrst) begin
            l_data_out <= '0;
        end else if (ctrl.finish) begin
            l_data_out <= ctrl.strided ? gathered : group_next;
        end
    end

endmodule

//--- verilog/lsu_sequencer.sv
`include "lsu_settings.svh"

module lsu_sequencer import lsu_pkg::*; (
    input  logic      clk,
    input  logic      nrst,
    input  lsu_op_t   op,
    input  lmul_t     lmul,
    input  mem_addr_t address,
    input  group_t    s_data,
    load_ctrl_if.seq  ctrl,
    output mem_addr_t data_addr0,
    output mem_addr_t data_addr1,
    output mem_addr_t data_addr2,
    output mem_addr_t data_addr3,
    output word_t     data_out0,
    output word_t     data_out1,
    output word_t     data_out2,
    output word_t     data_out3,
    output logic      dm_v_write,
    output logic      l_done,
    output logic      s_done
);

    lsu_state_t state_q;
    lsu_state_t state_d;

    // beat counter and the op captured on leaving idle
    beat_cnt_t cnt_q;
    beat_cnt_t beats_q;
    beat_cnt_t op_beats;
    logic      store_q;
    logic      strided_q;
    mem_addr_t base_q;

    logic is_load;
    logic is_sload;
    logic is_store;
    logic last_load;
    logic last_store;

    logic      addr_valid;
    logic      store_active;
    mem_addr_t beat_base;
    beat_t     store_beat;

    // op class
    always_comb begin
        is_load = 1'b0;
        is_sload = 1'b0;
        is_store = 1'b0;
        case (op)
            VLSU_VLE8, VLSU_VLE16, VLSU_VLE32: is_load = 1'b1;
            VLSU_VLSE8, VLSU_VLSE16, VLSU_VLSE32: is_sload = 1'b1;
            VLSU_VSE8, VLSU_VSE16, VLSU_VSE32: is_store = 1'b1;
            // none and the unused codes stay idle
            default: ;
        endcase
    end

    // beats per group from lmul, reserved codes as one beat
    always_comb begin
        case (lmul)
            3'd1: op_beats = beat_cnt_t'(2);
            3'd2: op_beats = beat_cnt_t'(4);
            default: op_beats = beat_cnt_t'(1);
        endcase
    end

    // load runs one cycle past the last address for the read latency
    assign last_load = (cnt_q == beats_q);
    assign last_store = (cnt_q == beats_q - beat_cnt_t'(1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (is_store) begin
                    state_d = ST_STORE;
                end else if (is_load || is_sload) begin
                    state_d = ST_LOAD;
                end
            end
            ST_LOAD: begin
                if (last_load) begin
                    state_d = strided_q ? ST_COMPACT : ST_DONE;
                end
            end
            ST_COMPACT: state_d = ST_DONE;
            ST_STORE: begin
                if (last_store) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                // issuer drops the op once it sees done
                if (op == VLSU_NONE) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state_q <= ST_IDLE;
            cnt_q <= '0;
            beats_q <= beat_cnt_t'(1);
            store_q <= 1'b0;
            strided_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE) begin
                cnt_q <= '0;
                beats_q <= op_beats;
                store_q <= is_store;
                strided_q <= is_sload;
            end else if (state_q == ST_LOAD || state_q == ST_STORE) begin
                cnt_q <= cnt_q + beat_cnt_t'(1);
            end
        end
    end

    // base word address held for the whole op
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE) begin
            base_q <= address;
        end
    end

    // bank b of beat k sits at base + 4k + b
    assign beat_base = base_q + mem_addr_t'(cnt_q * `LSU_BANKS);
    assign addr_valid = (state_q == ST_LOAD || state_q == ST_STORE) && (cnt_q < beats_q);

    assign data_addr0 = addr_valid ? beat_base : '0;
    assign data_addr1 = addr_valid ? beat_base + mem_addr_t'(1) : '0;
    assign data_addr2 = addr_valid ? beat_base + mem_addr_t'(2) : '0;
    assign data_addr3 = addr_valid ? beat_base + mem_addr_t'(3) : '0;

    // store beat k is bits 128k upward of s_data
    assign store_active = (state_q == ST_STORE);
    assign store_beat = s_data[beat_idx_t'(cnt_q)*`LSU_BEAT_W +: `LSU_BEAT_W];

    assign data_out0 = store_active ? store_beat[31:0] : '0;
    assign data_out1 = store_active ? store_beat[63:32] : '0;
    assign data_out2 = store_active ? store_beat[95:64] : '0;
    assign data_out3 = store_active ? store_beat[127:96] : '0;
    assign dm_v_write = store_active;

    // read data of beat c arrives in load cycle c+1
    assign ctrl.clear = (state_q == ST_LOAD) && (cnt_q == '0);
    assign ctrl.capture = (state_q == ST_LOAD) && (cnt_q != '0);
    assign ctrl.beat_idx = beat_idx_t'(cnt_q - beat_cnt_t'(1));
    assign ctrl.finish = ((state_q == ST_LOAD) && last_load && !strided_q)
                         || (state_q == ST_COMPACT);
    assign ctrl.strided = strided_q;

    // done level of the op class that finished
    assign l_done = (state_q == ST_DONE) && !store_q;
    assign s_done = (state_q == ST_DONE) && store_q;

endmodule

//--- verilog/lsu_top.sv
module lsu_top import lsu_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic [3:0] v_lsu_op,
    input  lmul_t      lmul,
    input  sew_t       vsew,
    input  stride_t    stride,
    input  mem_addr_t  address,
    input  group_t     s_data,
    input  word_t      l_data_in0,
    input  word_t      l_data_in1,
    input  word_t      l_data_in2,
    input  word_t      l_data_in3,
    output mem_addr_t  data_addr0,
    output mem_addr_t  data_addr1,
    output mem_addr_t  data_addr2,
    output mem_addr_t  data_addr3,
    output word_t      data_out0,
    output word_t      data_out1,
    output word_t      data_out2,
    output word_t      data_out3,
    output logic       dm_v_write,
    output group_t     l_data_out,
    output logic       l_done,
    output logic       s_done
);

    // raw op code as the enum, unknown codes decode as idle
    lsu_op_t op;
    assign op = lsu_op_t'(v_lsu_op);

    // load control, sequencer to assembler
    load_ctrl_if ctrl_if ();

    // owns all bank address and write ports
    lsu_sequencer u_seq (
        .clk        (clk),
        .nrst       (nrst),
        .op         (op),
        .lmul       (lmul),
        .address    (address),
        .s_data     (s_data),
        .ctrl       (ctrl_if.seq),
        .data_addr0 (data_addr0),
        .data_addr1 (data_addr1),
        .data_addr2 (data_addr2),
        .data_addr3 (data_addr3),
        .data_out0  (data_out0),
        .data_out1  (data_out1),
        .data_out2  (data_out2),
        .data_out3  (data_out3),
        .dm_v_write (dm_v_write),
        .l_done     (l_done),
        .s_done     (s_done)
    );

    // bank read data straight from the ports
    load_assembler u_asm (
        .clk        (clk),
        .nrst       (nrst),
        .ctrl       (ctrl_if.asm),
        .l_data_in0 (l_data_in0),
        .l_data_in1 (l_data_in1),
        .l_data_in2 (l_data_in2),
        .l_data_in3 (l_data_in3),
        .vsew       (vsew),
        .stride     (stride),
        .l_data_out (l_data_out)
    );

endmodule

//--- dv/clk_gen.sv
module clk_gen (
    output logic clk,
    output logic nrst
);

    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for 10 cycles, released on a falling edge
    initial begin
        nrst = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
    end

endmodule

//--- dv/lsu_checker.sv
module lsu_checker import lsu_pkg::*; (
    input  logic      clk,
    input  logic      nrst,
    // 0 idle, 1 load, 2 store
    input  logic [1:0] kind,
    input  group_t    exp_group,
    input  mem_addr_t exp_base,
    input  int        exp_beats,
    input  int        exp_lat,
    input  mem_addr_t data_addr0,
    input  mem_addr_t data_addr1,
    input  mem_addr_t data_addr2,
    input  mem_addr_t data_addr3,
    input  word_t     data_out0,
    input  word_t     data_out1,
    input  word_t     data_out2,
    input  word_t     data_out3,
    input  logic      dm_v_write,
    input  group_t    l_data_out,
    input  logic      l_done,
    input  logic      s_done,
    output int        errors
);

    timeunit 1ns;
    timeprecision 1ps;

    int     t;
    int     wr_cnt;
    int     quiet;
    logic   seen;
    group_t held;

    initial begin
        errors = 0;
        t = 0;
        wr_cnt = 0;
        quiet = 0;
        seen = 1'b0;
        held = '0;
    end

    // sampled on the rising edge, stimulus moves on the falling edge
    always @(posedge clk) begin
        logic      done;
        logic      other;
        word_t     words[4];
        mem_addr_t addrs[4];
        words = '{data_out0, data_out1, data_out2, data_out3};
        addrs = '{data_addr0, data_addr1, data_addr2, data_addr3};
        if (!nrst) begin
            quiet = 0;
        end else if (kind == 2'd0) begin
            t = 0;
            wr_cnt = 0;
            seen = 1'b0;
            // unit needs one edge to see the op drop
            if (quiet >= 1 && (dm_v_write || l_done || s_done)) begin
                $display("Mismatch at %0t: write or done while idle", $time);
                errors++;
            end
            quiet++;
        end else begin
            quiet = 0;
            done = (kind == 2'd2) ? s_done : l_done;
            other = (kind == 2'd2) ? l_done : s_done;
            if (other) begin
                $display("Mismatch at %0t: done of the wrong op class", $time);
                errors++;
            end
            if (dm_v_write) begin
                if (kind != 2'd2 || wr_cnt >= exp_beats) begin
                    $display("Mismatch at %0t: unexpected write, beat %0d", $time, wr_cnt);
                    errors++;
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (addrs[b] != mem_addr_t'(exp_base + 4 * wr_cnt + b)
                            || words[b] != exp_group[128*wr_cnt+32*b +: 32]) begin
                            $display("Mismatch at %0t: store beat %0d bank %0d addr %h data %h",
                                     $time, wr_cnt, b, addrs[b], words[b]);
                            errors++;
                        end
                    end
                end
                wr_cnt++;
            end
            if (done && !seen) begin
                seen = 1'b1;
                held = l_data_out;
                if (t != exp_lat) begin
                    $display("Mismatch at %0t: done after %0d cycles, expected %0d",
                             $time, t, exp_lat);
                    errors++;
                end
                if (kind == 2'd1 && l_data_out != exp_group) begin
                    $display("Mismatch at %0t: load result %h expected %h",
                             $time, l_data_out, exp_group);
                    errors++;
                end
                if (kind == 2'd2 && wr_cnt != exp_beats) begin
                    $display("Mismatch at %0t: %0d store beats, expected %0d",
                             $time, wr_cnt, exp_beats);
                    errors++;
                end
            end else if (seen) begin
                // done level and result hold until the op drops
                if (!done || l_data_out != held) begin
                    $display("Mismatch at %0t: done or result changed while held", $time);
                    errors++;
                end
            end else begin
                t++;
            end
        end
    end

endmodule

//--- dv/tb_lsu.sv
module tb_lsu import lsu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic       clk;
    logic       nrst;
    logic [3:0] v_lsu_op;
    lmul_t      lmul;
    sew_t       vsew;
    stride_t    stride;
    mem_addr_t  address;
    group_t     s_data;
    word_t      rd[4];
    mem_addr_t  data_addr0, data_addr1, data_addr2, data_addr3;
    word_t      data_out0, data_out1, data_out2, data_out3;
    logic       dm_v_write;
    group_t     l_data_out;
    logic       l_done;
    logic       s_done;

    // expected values handed to the checker
    logic [1:0] kind;
    group_t     exp_group;
    mem_addr_t  exp_base;
    int         exp_beats;
    int         exp_lat;
    int         errors;

    // four banks of 2^14 words
    word_t mem[4][16384];
    logic [31:0] rng;

    // stimulus table
    int t_op[$], t_lmul[$], t_sew[$], t_stride[$], t_addr[$], t_seed[$];
    int cycles;
    int limit;

    clk_gen u_clk (.clk(clk), .nrst(nrst));

    lsu_top dut (
        .clk(clk), .nrst(nrst), .v_lsu_op(v_lsu_op), .lmul(lmul), .vsew(vsew),
        .stride(stride), .address(address), .s_data(s_data),
        .l_data_in0(rd[0]), .l_data_in1(rd[1]), .l_data_in2(rd[2]), .l_data_in3(rd[3]),
        .data_addr0(data_addr0), .data_addr1(data_addr1),
        .data_addr2(data_addr2), .data_addr3(data_addr3),
        .data_out0(data_out0), .data_out1(data_out1),
        .data_out2(data_out2), .data_out3(data_out3),
        .dm_v_write(dm_v_write), .l_data_out(l_data_out), .l_done(l_done), .s_done(s_done)
    );

    lsu_checker u_chk (
        .clk(clk), .nrst(nrst), .kind(kind), .exp_group(exp_group), .exp_base(exp_base),
        .exp_beats(exp_beats), .exp_lat(exp_lat),
        .data_addr0(data_addr0), .data_addr1(data_addr1),
        .data_addr2(data_addr2), .data_addr3(data_addr3),
        .data_out0(data_out0), .data_out1(data_out1),
        .data_out2(data_out2), .data_out3(data_out3),
        .dm_v_write(dm_v_write), .l_data_out(l_data_out), .l_done(l_done), .s_done(s_done),
        .errors(errors)
    );

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int beats_of(input int lm);
        return (lm == 1) ? 2 : (lm == 2) ? 4 : 1;
    endfunction

    // synchronous bank reads, writes at the end of a write cycle
    always @(posedge clk) begin
        rd[0] <= mem[0][data_addr0];
        rd[1] <= mem[1][data_addr1];
        rd[2] <= mem[2][data_addr2];
        rd[3] <= mem[3][data_addr3];
        if (dm_v_write) begin
            mem[0][data_addr0] <= data_out0;
            mem[1][data_addr1] <= data_out1;
            mem[2][data_addr2] <= data_out2;
            mem[3][data_addr3] <= data_out3;
        end
    end

    // run limit from the table length
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("errors: %0d", errors);
            $display("tests failed");
            $finish;
        end
    end

    task automatic add_row(input int op, input int lm, input int sw, input int st,
                           input int ad, input int sd);
        t_op.push_back(op);
        t_lmul.push_back(lm);
        t_sew.push_back(sw);
        t_stride.push_back(st);
        t_addr.push_back(ad);
        t_seed.push_back(sd);
    endtask

    // raw group from the bank model, then compaction for strided loads
    task automatic expect_load(input int r);
        group_t raw;
        int n;
        int ew;
        int ne;
        int src;
        raw = '0;
        n = beats_of(t_lmul[r]);
        for (int k = 0; k < n; k++) begin
            for (int b = 0; b < 4; b++) begin
                raw[128*k+32*b +: 32] = mem[b][mem_addr_t'(t_addr[r] + 4 * k + b)];
            end
        end
        ew = (t_sew[r] == 0) ? 8 : (t_sew[r] == 1) ? 16 : 32;
        ne = 512 / ew;
        exp_group = raw;
        if (t_op[r] >= 4 && t_op[r] <= 6 && t_stride[r] > 1) begin
            exp_group = '0;
            for (int i = 0; i < ne; i++) begin
                src = i * t_stride[r];
                if (src < ne) begin
                    for (int j = 0; j < ew; j++) begin
                        exp_group[i*ew+j] = raw[src*ew+j];
                    end
                end
            end
        end
    endtask

    initial begin
        logic [31:0] sd;
        int n;
        v_lsu_op = 4'd0;
        lmul = '0;
        vsew = '0;
        stride = '0;
        address = '0;
        s_data = '0;
        rd = '{default: '0};
        kind = 2'd0;
        exp_group = '0;
        exp_base = '0;
        exp_beats = 1;
        exp_lat = 0;
        cycles = 0;
        limit = 1000000;
        rng = 32'd28;
        for (int a = 0; a < 16384; a++) begin
            for (int b = 0; b < 4; b++) begin
                rng = lcg(rng);
                mem[b][a] = rng ^ {16'h0, a[13:0], b[1:0]};
            end
        end
        // unit-stride loads, including a reserved lmul code and a wrapping address
        for (int lm = 0; lm < 4; lm++) add_row(1 + (lm % 3), lm, 0, 0, 40 + 16 * lm, 0);
        add_row(3, 2, 2, 0, 16380, 0);
        // strided loads per element width
        for (int sw = 0; sw < 3; sw++) begin
            add_row(4 + sw, 2, sw, 0, 300, 0);
            add_row(4 + sw, 2, sw, 1, 300, 0);
            add_row(4 + sw, 2, sw, 2, 500, 0);
            add_row(4 + sw, 1, sw, 3, 700, 0);
            add_row(4 + sw, 2, sw, 7, 900, 0);
        end
        add_row(6, 2, 2, 20, 1100, 0);
        add_row(5, 2, 1, 40, 1200, 0);
        add_row(5, 0, 3, 5, 1300, 0);
        // stores then reload of the same place
        for (int lm = 0; lm < 3; lm++) add_row(7 + lm, lm, 0, 0, 2000, 11 + lm);
        add_row(1, 2, 0, 0, 2000, 0);
        // strided-store codes act as idle
        for (int op = 10; op <= 12; op++) add_row(op, 2, 0, 2, 3000, 5);
        for (int r = 0; r < 12; r++) begin
            rng = lcg(rng);
            add_row(1 + (rng[27:16] % 9), rng[9:8], rng[11:10] % 3, rng[5:0],
                    rng[31:18], rng[15:0]);
        end
        limit = 60;
        foreach (t_op[r]) limit += beats_of(t_lmul[r]) + 6;
        @(posedge nrst);
        // a couple of idle cycles straight out of reset
        repeat (2) @(negedge clk);
        for (int r = 0; r < t_op.size(); r++) begin
            n = beats_of(t_lmul[r]);
            sd = t_seed[r];
            for (int w = 0; w < 16; w++) begin
                sd = lcg(sd);
                s_data[32*w +: 32] = sd;
            end
            expect_load(r);
            exp_base = mem_addr_t'(t_addr[r]);
            exp_beats = n;
            if (t_op[r] >= 7 && t_op[r] <= 9) begin
                kind = 2'd2;
                exp_group = s_data;
                exp_lat = n + 1;
            end else if (t_op[r] >= 1 && t_op[r] <= 6) begin
                kind = 2'd1;
                exp_lat = (t_op[r] >= 4) ? n + 3 : n + 2;
            end else begin
                kind = 2'd0;
            end
            v_lsu_op = 4'(t_op[r]);
            lmul = lmul_t'(t_lmul[r]);
            vsew = sew_t'(t_sew[r]);
            stride = stride_t'(t_stride[r]);
            address = mem_addr_t'(t_addr[r]);
            if (kind == 2'd0) begin
                repeat (4) @(negedge clk);
            end else begin
                @(negedge clk);
                while (!(l_done || s_done)) @(negedge clk);
                // keep the op up past done so the held level is seen
                repeat (2) @(negedge clk);
            end
            v_lsu_op = 4'd0;
            kind = 2'd0;
            repeat (2) @(negedge clk);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+include
verilog/lsu_pkg.sv
verilog/load_ctrl_if.sv
verilog/element_gather.sv
verilog/load_assembler.sv
verilog/lsu_sequencer.sv
verilog/lsu_top.sv
dv/clk_gen.sv
dv/lsu_checker.sv
dv/tb_lsu.sv

//--- run.sh
#!/bin/sh
# compile and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_lsu -f all.f -o sim_lsu \
    > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "^all tests passed$" sim.log; then
    exit 0
fi
exit 1
